// File: hdl/sys_pkg.sv
// -------------------------------------------------------------------
// shared system definitions for the two-node memory system
// widths, address map, opcodes and the request/response/flit structs
// -------------------------------------------------------------------

package sys_pkg;

    // number of request nodes behind the arbiter
    localparam int NUM_NODES = 2;

    // word address and data widths of the memory side
    localparam int ADDR_W = 10;
    localparam int DATA_W = 32;

    // console characters are plain 7-bit ascii
    localparam int ASCII_W = 7;

    // width of the led status register
    localparam int LED_W = 8;

    // -------------------------------------------------------------------
    // address map
    // -------------------------------------------------------------------

    // a write here queues the low 7 data bits as one console character
    localparam logic [ADDR_W-1:0] CONSOLE_ADDR = 10'h3F0;

    // the led status register, read back zero-extended
    localparam logic [ADDR_W-1:0] LED_ADDR = 10'h3F1;

    // -------------------------------------------------------------------
    // types
    // -------------------------------------------------------------------

    // source id carried with every flit so the answer finds its way back
    typedef logic [$clog2(NUM_NODES)-1:0] node_id_t;

    typedef logic [ASCII_W-1:0] ascii_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    // one word request, valid is a strobe on the node side
    typedef struct packed {
        logic                valid;
        req_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } mem_req_t;

    // answer to a request, rdata is zero for writes
    typedef struct packed {
        logic                valid;
        logic [DATA_W-1:0]   rdata;
    } mem_rsp_t;

    // a request tagged with the node it came from
    typedef struct packed {
        node_id_t            src;
        mem_req_t            req;
    } flit_t;

endpackage

// File: hdl/node_port.sv
// -------------------------------------------------------------------
// node port, holds one request until the arbiter grants it
// and hands the steered answer back as a one-cycle strobe
// -------------------------------------------------------------------

module node_port
#(
     parameter sys_pkg::node_id_t NODE_ID = '0
)
(
     input  logic              clk
    ,input  logic              rst_n

    ,input  sys_pkg::mem_req_t req
    ,input  logic              grant
    ,input  sys_pkg::mem_rsp_t rsp_in

    ,output sys_pkg::flit_t    flit
    ,output sys_pkg::mem_rsp_t rsp
);

    // a node has at most one transaction in flight
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PENDING,
        ST_WAIT_RSP
    } state_e;

    state_e                      state_q;
    sys_pkg::mem_req_t           req_q;
    logic                        rsp_valid_q;
    logic [sys_pkg::DATA_W-1:0]  rsp_data_q;

    // -------------------------------------------------------------------
    // transaction state
    // -------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            rsp_valid_q <= 1'b0;
        end else begin
            // the response strobe lasts a single cycle
            rsp_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (req.valid) begin
                        state_q <= ST_PENDING;
                    end
                end
                ST_PENDING: begin
                    // the grant is a one-cycle pulse from the arbiter
                    if (grant) begin
                        state_q <= ST_WAIT_RSP;
                    end
                end
                ST_WAIT_RSP: begin
                    if (rsp_in.valid) begin
                        rsp_valid_q <= 1'b1;
                        state_q     <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // request and answer payload, captured only when they are taken
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req.valid) begin
            req_q <= req;
        end
        if (state_q == ST_WAIT_RSP && rsp_in.valid) begin
            rsp_data_q <= rsp_in.rdata;
        end
    end

    // the flit stays valid for as long as the request waits for a grant
    always_comb begin
        flit.src       = NODE_ID;
        flit.req       = req_q;
        flit.req.valid = (state_q == ST_PENDING);
    end

    assign rsp = '{valid: rsp_valid_q, rdata: rsp_data_q};

    // the requester must wait for the answer before it strobes again
    a_no_req_while_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        req.valid |-> state_q == ST_IDLE
    );

endmodule

// File: hdl/noc_arbiter.sv
// -------------------------------------------------------------------
// two-input round-robin arbiter toward the memory controller
// that also steers each answer back to its node by source id
// -------------------------------------------------------------------

module noc_arbiter
(
     input  logic              clk
    ,input  logic              rst_n

    ,input  sys_pkg::flit_t    flit_0
    ,input  sys_pkg::flit_t    flit_1

    ,input  sys_pkg::mem_rsp_t mem_rsp
    ,input  sys_pkg::node_id_t mem_rsp_src

    ,output logic              grant_0
    ,output logic              grant_1
    ,output sys_pkg::flit_t    mem_flit

    ,output sys_pkg::mem_rsp_t rsp_0
    ,output sys_pkg::mem_rsp_t rsp_1
);

    localparam sys_pkg::node_id_t NODE_0 = sys_pkg::node_id_t'(0);
    localparam sys_pkg::node_id_t NODE_1 = sys_pkg::node_id_t'(1);

    // points at the node that wins the next tie
    sys_pkg::node_id_t rr_q;

    logic req_0;
    logic req_1;

    assign req_0 = flit_0.req.valid;
    assign req_1 = flit_1.req.valid;

    // -------------------------------------------------------------------
    // selection
    // -------------------------------------------------------------------

    // a lone request always wins and a tie goes to the node under the pointer
    assign grant_0 = req_0 && (!req_1 || rr_q == NODE_0);
    assign grant_1 = req_1 && (!req_0 || rr_q == NODE_1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_q <= NODE_0;
        end else if (req_0 && req_1) begin
            // the loser of this tie wins the next one
            rr_q <= ~rr_q;
        end
    end

    // with no grant flit_0 is idle too, so its low valid goes through
    assign mem_flit = grant_1 ? flit_1 : flit_0;

    // -------------------------------------------------------------------
    // response steering
    // -------------------------------------------------------------------

    // both nodes see the data but only the addressed one sees valid
    always_comb begin
        rsp_0       = mem_rsp;
        rsp_1       = mem_rsp;
        rsp_0.valid = mem_rsp.valid && (mem_rsp_src == NODE_0);
        rsp_1.valid = mem_rsp.valid && (mem_rsp_src == NODE_1);
    end

    // answers come back by source id, so a forwarded flit must carry the granted node
    a_grant_src : assert property (
        @(posedge clk) disable iff (!rst_n)
        (grant_0 || grant_1) |-> mem_flit.src == (grant_1 ? NODE_1 : NODE_0)
    );

    // the node that loses a tie is served in the very next cycle
    a_loser_next : assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_0 && req_1) |=> ($past(grant_0) ? grant_1 : grant_0)
    );

endmodule

// File: hdl/memory_controller.sv
// -------------------------------------------------------------------
// memory controller with word ram, led register and console port,
// answers every forwarded flit one cycle later
// -------------------------------------------------------------------

module memory_controller
#(
     parameter int MEM_WORDS = 256
)
(
     input  logic                        clk
    ,input  logic                        rst_n

    ,input  sys_pkg::flit_t              flit

    ,output sys_pkg::mem_rsp_t           rsp
    ,output sys_pkg::node_id_t           rsp_src

    ,output logic [sys_pkg::LED_W-1:0]   leds_status
    ,output sys_pkg::ascii_t             console_char
    ,output logic                        console_valid
);

    localparam int RAM_AW = $clog2(MEM_WORDS);

    logic [sys_pkg::DATA_W-1:0] ram [MEM_WORDS];

    logic                        hit_ram;
    logic                        hit_led;
    logic                        hit_console;
    logic                        do_read;
    logic                        do_write;
    logic [RAM_AW-1:0]           ram_idx;

    logic                        rsp_valid_q;
    logic [sys_pkg::DATA_W-1:0]  rdata_q;
    sys_pkg::node_id_t           src_q;
    logic [sys_pkg::LED_W-1:0]   leds_q;
    logic                        console_valid_q;
    sys_pkg::ascii_t             console_char_q;

    // -------------------------------------------------------------------
    // address decode
    // -------------------------------------------------------------------

    // the registers sit on top of the map and win over the ram range
    always_comb begin
        hit_led     = (flit.req.addr == sys_pkg::LED_ADDR);
        hit_console = (flit.req.addr == sys_pkg::CONSOLE_ADDR);
        hit_ram     = !hit_led && !hit_console && (flit.req.addr < MEM_WORDS);
        do_read     = flit.req.valid && (flit.req.op == sys_pkg::OP_READ);
        do_write    = flit.req.valid && (flit.req.op == sys_pkg::OP_WRITE);
    end

    assign ram_idx = flit.req.addr[RAM_AW-1:0];

    // -------------------------------------------------------------------
    // storage and answer
    // -------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (do_write && hit_ram) begin
            ram[ram_idx] <= flit.req.wdata;
        end
    end

    // writes, console reads and unmapped reads all answer with zero
    always_ff @(posedge clk) begin
        if (flit.req.valid) begin
            src_q   <= flit.src;
            rdata_q <= '0;
            if (do_read && hit_ram) begin
                rdata_q <= ram[ram_idx];
            end else if (do_read && hit_led) begin
                rdata_q <= {{(sys_pkg::DATA_W - sys_pkg::LED_W){1'b0}}, leds_q};
            end
        end
        if (do_write && hit_console) begin
            console_char_q <= flit.req.wdata[sys_pkg::ASCII_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q     <= 1'b0;
            console_valid_q <= 1'b0;
            leds_q          <= '0;
        end else begin
            // every forwarded flit gets exactly one answer
            rsp_valid_q     <= flit.req.valid;
            console_valid_q <= do_write && hit_console;
            if (do_write && hit_led) begin
                leds_q <= flit.req.wdata[sys_pkg::LED_W-1:0];
            end
        end
    end

    assign rsp           = '{valid: rsp_valid_q, rdata: rdata_q};
    assign rsp_src       = src_q;
    assign leds_status   = leds_q;
    assign console_char  = console_char_q;
    assign console_valid = console_valid_q;

endmodule

// File: hdl/ring_buffer.sv
// -------------------------------------------------------------------
// console ring buffer that drops characters when full
// and drains one per cycle while the receiver is not busy
// -------------------------------------------------------------------

module ring_buffer
#(
     parameter int BUF_DEPTH = 16
)
(
     input  logic            clk
    ,input  logic            rst_n

    ,input  sys_pkg::ascii_t data_in
    ,input  logic            data_in_valid
    ,input  logic            recv_busy

    ,output sys_pkg::ascii_t data_out
    ,output logic            data_out_valid
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    sys_pkg::ascii_t   buf_q [BUF_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;

    logic full;
    logic empty;
    logic push;
    logic pop;

    // pointers wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count_q == CNT_W'(BUF_DEPTH));
    assign empty = (count_q == '0);
    assign push  = data_in_valid && !full;
    assign pop   = !empty && !recv_busy;

    // the head is offered directly and a push lands one cycle before it can leave
    assign data_out       = buf_q[rd_ptr_q];
    assign data_out_valid = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr_q] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // an empty or a full buffer has both pointers on the same slot
    a_ptr_match : assert property (
        @(posedge clk) disable iff (!rst_n)
        (empty || full) |-> wr_ptr_q == rd_ptr_q
    );

endmodule

// File: hdl/sys_top.sv
// -------------------------------------------------------------------
// memory system top, two node ports sharing one memory controller
// through the arbiter, with the console ring buffer on the side
// -------------------------------------------------------------------

module sys_top
#(
     parameter int BUF_DEPTH = 16
    ,parameter int MEM_WORDS = 256
)
(
     input  logic                        clk
    ,input  logic                        rst_n

    ,input  sys_pkg::mem_req_t           req_0
    ,input  sys_pkg::mem_req_t           req_1
    ,output sys_pkg::mem_rsp_t           rsp_0
    ,output sys_pkg::mem_rsp_t           rsp_1

    ,output sys_pkg::ascii_t             buffer_out_data
    ,output logic                        buffer_out_valid
    ,input  logic                        buffer_recv_busy

    ,output logic [sys_pkg::LED_W-1:0]   leds_status
);

    // node side of the arbiter
    sys_pkg::flit_t    w_flit_0;
    sys_pkg::flit_t    w_flit_1;
    logic              w_grant_0;
    logic              w_grant_1;
    sys_pkg::mem_rsp_t w_rsp_0;
    sys_pkg::mem_rsp_t w_rsp_1;

    // memory side of the arbiter
    sys_pkg::flit_t    w_mem_flit;
    sys_pkg::mem_rsp_t w_mem_rsp;
    sys_pkg::node_id_t w_mem_rsp_src;

    // console characters on their way to the ring buffer
    sys_pkg::ascii_t   w_console_char;
    logic              w_console_valid;

    // -------------------------------------------------------------------
    // nodes and arbiter
    // -------------------------------------------------------------------

    node_port #( .NODE_ID( sys_pkg::node_id_t'(0) ) ) node_port_0_inst
    (
         .clk( clk )
        ,.rst_n( rst_n )
        ,.req( req_0 )
        ,.grant( w_grant_0 )
        ,.rsp_in( w_rsp_0 )
        ,.flit( w_flit_0 )
        ,.rsp( rsp_0 )
    );

    node_port #( .NODE_ID( sys_pkg::node_id_t'(1) ) ) node_port_1_inst
    (
         .clk( clk )
        ,.rst_n( rst_n )
        ,.req( req_1 )
        ,.grant( w_grant_1 )
        ,.rsp_in( w_rsp_1 )
        ,.flit( w_flit_1 )
        ,.rsp( rsp_1 )
    );

    noc_arbiter noc_arbiter_inst
    (
         .clk( clk )
        ,.rst_n( rst_n )
        ,.flit_0( w_flit_0 )
        ,.flit_1( w_flit_1 )
        ,.mem_rsp( w_mem_rsp )
        ,.mem_rsp_src( w_mem_rsp_src )
        ,.grant_0( w_grant_0 )
        ,.grant_1( w_grant_1 )
        ,.mem_flit( w_mem_flit )
        ,.rsp_0( w_rsp_0 )
        ,.rsp_1( w_rsp_1 )
    );

    // -------------------------------------------------------------------
    // memory and console
    // -------------------------------------------------------------------

    memory_controller #( .MEM_WORDS( MEM_WORDS ) ) memory_controller_inst
    (
         .clk( clk )
        ,.rst_n( rst_n )
        ,.flit( w_mem_flit )
        ,.rsp( w_mem_rsp )
        ,.rsp_src( w_mem_rsp_src )
        ,.leds_status( leds_status )
        ,.console_char( w_console_char )
        ,.console_valid( w_console_valid )
    );

    ring_buffer #( .BUF_DEPTH( BUF_DEPTH ) ) ring_buffer_inst
    (
         .clk( clk )
        ,.rst_n( rst_n )
        ,.data_in( w_console_char )
        ,.data_in_valid( w_console_valid )
        ,.recv_busy( buffer_recv_busy )
        ,.data_out( buffer_out_data )
        ,.data_out_valid( buffer_out_valid )
    );

endmodule

// File: tests/tb_sys_top.sv
// -------------------------------------------------------------------
// testbench for the two-node memory system, drives both node ports
// and checks answers, led register and console output against a model
// -------------------------------------------------------------------

module tb_sys_top;

    localparam int BUF_DEPTH   = 16;
    localparam int MEM_WORDS   = 256;
    localparam int MAX_LATENCY = 5;
    // the whole sequence needs a few hundred cycles and the limit leaves ample margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                        clk;
    logic                        rst_n;
    sys_pkg::mem_req_t           req_0;
    sys_pkg::mem_req_t           req_1;
    sys_pkg::mem_rsp_t           rsp_0;
    sys_pkg::mem_rsp_t           rsp_1;
    sys_pkg::ascii_t             buffer_out_data;
    logic                        buffer_out_valid;
    logic                        buffer_recv_busy;
    logic [sys_pkg::LED_W-1:0]   leds_status;

    // reference state mirrors ram, led register and the queued console text
    logic [sys_pkg::DATA_W-1:0]  model_mem [MEM_WORDS];
    logic [sys_pkg::LED_W-1:0]   model_leds;
    sys_pkg::ascii_t             exp_chars [$];

    // expected answers and issue cycles are kept in one queue pair per node
    logic [sys_pkg::DATA_W-1:0]  exp_rsp_0 [$];
    logic [sys_pkg::DATA_W-1:0]  exp_rsp_1 [$];
    int                          issue_cyc_0 [$];
    int                          issue_cyc_1 [$];

    int     rsp_count_0 = 0;
    int     rsp_count_1 = 0;
    int     chars_seen = 0;
    int     cycles = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    integer seed;
    string  test_name = "reset";

    sys_top #( .BUF_DEPTH( BUF_DEPTH ), .MEM_WORDS( MEM_WORDS ) ) sys_top_i
    (
         .clk( clk )
        ,.rst_n( rst_n )
        ,.req_0( req_0 )
        ,.req_1( req_1 )
        ,.rsp_0( rsp_0 )
        ,.rsp_1( rsp_1 )
        ,.buffer_out_data( buffer_out_data )
        ,.buffer_out_valid( buffer_out_valid )
        ,.buffer_recv_busy( buffer_recv_busy )
        ,.leds_status( leds_status )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
    end

    // a lost answer or character must not stall the run
    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        other_errors++;
        $display("timeout after %0d cycles, a response or character never arrived", cycles);
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        $display("=== FAIL ===");
        $finish;
    end

    // -------------------------------------------------------------------
    // reference model and checks
    // -------------------------------------------------------------------

    // applies one access to the model and returns the answer the DUT owes
    function automatic logic [31:0] model_access(input logic is_write,
                                                 input logic [sys_pkg::ADDR_W-1:0] addr,
                                                 input logic [31:0] wdata);
        if (is_write) begin
            if (addr == sys_pkg::LED_ADDR) begin
                model_leds = wdata[sys_pkg::LED_W-1:0];
            end else if (addr == sys_pkg::CONSOLE_ADDR) begin
                // a full buffer loses the character
                if (exp_chars.size() < BUF_DEPTH) begin
                    exp_chars.push_back(wdata[sys_pkg::ASCII_W-1:0]);
                end
            end else if (addr < MEM_WORDS) begin
                model_mem[addr] = wdata;
            end
            return 32'h0;
        end
        if (addr == sys_pkg::LED_ADDR) begin
            return {24'h0, model_leds};
        end
        if (addr != sys_pkg::CONSOLE_ADDR && addr < MEM_WORDS) begin
            return model_mem[addr];
        end
        return 32'h0;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_response(input int node, input logic [31:0] rdata);
        logic [31:0] exp;
        int          issued;
        int          pending;
        pending = (node == 0) ? exp_rsp_0.size() : exp_rsp_1.size();
        assert (pending > 0) else begin
            other_errors++;
            $display("node %0d answered with no request outstanding", node);
        end
        if (pending > 0) begin
            if (node == 0) begin
                exp    = exp_rsp_0.pop_front();
                issued = issue_cyc_0.pop_front();
                rsp_count_0++;
            end else begin
                exp    = exp_rsp_1.pop_front();
                issued = issue_cyc_1.pop_front();
                rsp_count_1++;
            end
            assert (cycles - issued <= MAX_LATENCY) else begin
                other_errors++;
                $display("node %0d answer took %0d cycles", node, cycles - issued);
            end
            check_value($sformatf("node %0d rdata", node), exp, rdata);
        end
    endtask

    task automatic check_character(input sys_pkg::ascii_t ch);
        sys_pkg::ascii_t exp;
        assert (!buffer_recv_busy) else begin
            other_errors++;
            $display("console character left the buffer while the receiver was busy");
        end
        assert (exp_chars.size() > 0) else begin
            other_errors++;
            $display("console character %h appeared with none expected", ch);
        end
        if (exp_chars.size() > 0) begin
            exp = exp_chars.pop_front();
            check_value("console char", 32'(exp), 32'(ch));
        end
        chars_seen++;
    endtask

    // the compare process samples outputs mid-cycle where they have settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (rsp_0.valid) begin
                check_response(0, rsp_0.rdata);
            end
            if (rsp_1.valid) begin
                check_response(1, rsp_1.rdata);
            end
            if (buffer_out_valid) begin
                check_character(buffer_out_data);
            end
        end
    end

    // -------------------------------------------------------------------
    // stimulus
    // -------------------------------------------------------------------

    // one strobe on a node port, then wait for its answer
    task automatic send_request(input int node, input sys_pkg::req_op_e op,
                                input logic [sys_pkg::ADDR_W-1:0] addr,
                                input logic [31:0] wdata);
        sys_pkg::mem_req_t r;
        logic [31:0]       exp;
        int                target;
        r.valid = 1'b1;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        exp = model_access(op == sys_pkg::OP_WRITE, addr, wdata);
        @(posedge clk);
        #2;
        if (node == 0) begin
            exp_rsp_0.push_back(exp);
            issue_cyc_0.push_back(cycles);
            target = rsp_count_0 + 1;
            req_0  = r;
        end else begin
            exp_rsp_1.push_back(exp);
            issue_cyc_1.push_back(cycles);
            target = rsp_count_1 + 1;
            req_1  = r;
        end
        @(posedge clk);
        #2;
        if (node == 0) begin
            req_0 = '0;
            wait (rsp_count_0 >= target);
        end else begin
            req_1 = '0;
            wait (rsp_count_1 >= target);
        end
    endtask

    task automatic drain_console();
        while (exp_chars.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        logic [sys_pkg::ADDR_W-1:0] addrs [8];
        logic [31:0]                data;
        int                         seen_before;
        seed = 32'hc286;
        rst_n = 1'b0;
        req_0 = '0;
        req_1 = '0;
        buffer_recv_busy = 1'b0;
        model_leds = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        repeat (3) begin
            @(negedge clk);
            check_value("rsp_0 valid", 32'h0, 32'(rsp_0.valid));
            check_value("rsp_1 valid", 32'h0, 32'(rsp_1.valid));
            check_value("out valid", 32'h0, 32'(buffer_out_valid));
            check_value("leds", 32'h0, 32'(leds_status));
        end

        test_name = "single_node";
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $unsigned($random(seed)) % MEM_WORDS;
            send_request(0, sys_pkg::OP_WRITE, addrs[i], $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            send_request(0, sys_pkg::OP_READ, addrs[i], 32'h0);
        end

        // both nodes strobe in the same cycle and the arbiter serializes them
        test_name = "both_nodes";
        for (int i = 0; i < 4; i++) begin
            fork
                send_request(0, sys_pkg::OP_WRITE, 100 + i, $random(seed));
                send_request(1, sys_pkg::OP_WRITE, 200 + i, $random(seed));
            join
        end
        for (int i = 0; i < 4; i++) begin
            fork
                send_request(0, sys_pkg::OP_READ, 100 + i, 32'h0);
                send_request(1, sys_pkg::OP_READ, 200 + i, 32'h0);
            join
        end

        test_name = "led";
        data = $random(seed);
        send_request(1, sys_pkg::OP_WRITE, sys_pkg::LED_ADDR, data);
        check_value("leds", 32'(data[7:0]), 32'(leds_status));
        send_request(0, sys_pkg::OP_READ, sys_pkg::LED_ADDR, 32'h0);
        send_request(0, sys_pkg::OP_READ, sys_pkg::CONSOLE_ADDR, 32'h0);

        // only the low 7 data bits reach the console and the upper ones are noise
        test_name = "console_order";
        for (int i = 0; i < 4; i++) begin
            data = ($random(seed) & 32'hffff_ff80) | (32'h41 + i);
            send_request(0, sys_pkg::OP_WRITE, sys_pkg::CONSOLE_ADDR, data);
        end
        drain_console();
        #2;
        buffer_recv_busy = 1'b1;
        seen_before = chars_seen;
        for (int i = 0; i < 5; i++) begin
            send_request(i % 2, sys_pkg::OP_WRITE, sys_pkg::CONSOLE_ADDR, 32'h30 + i);
        end
        repeat (10) @(posedge clk);
        check_value("chars while busy", 32'(seen_before), 32'(chars_seen));
        #2;
        buffer_recv_busy = 1'b0;
        drain_console();

        test_name = "console_overflow";
        @(posedge clk);
        #2;
        buffer_recv_busy = 1'b1;
        seen_before = chars_seen;
        for (int i = 0; i < BUF_DEPTH + 3; i++) begin
            send_request(0, sys_pkg::OP_WRITE, sys_pkg::CONSOLE_ADDR, 32'h61 + i);
        end
        repeat (4) @(posedge clk);
        #2;
        buffer_recv_busy = 1'b0;
        drain_console();
        check_value("chars after overflow", BUF_DEPTH, 32'(chars_seen - seen_before));

        assert (exp_rsp_0.size() == 0 && exp_rsp_1.size() == 0) else begin
            other_errors++;
            $display("requests were left without an answer at the end of the run");
        end
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/sys_pkg.sv
hdl/node_port.sv
hdl/noc_arbiter.sv
hdl/memory_controller.sv
hdl/ring_buffer.sv
hdl/sys_top.sv
tests/tb_sys_top.sv
